// ==== bench/shared_icache_props.sv ====
`default_nettype none

module shared_icache_props
   import icache_pkg::*;
(
   input wire        clk,
   input wire        reset_i,
   input core_vec_t  fetch_gnt_i,
   input wire        pf_gnt_i,
   input wire        ar_valid_i,
   input wire        ar_ready_i,
   input addr_t      ar_addr_i,
   input wire        flush_i,
   input wire        flush_ack_i
);

   logic flush_open_q;   // Between strobe and ack

   always_ff @(posedge clk) begin
      if (reset_i)          flush_open_q <= 1'b0;
      else if (flush_ack_i) flush_open_q <= 1'b0;
      else if (flush_i)     flush_open_q <= 1'b1;
   end

   ////////////////////
   // Handshake rules
   ////////////////////
   one_grant_a : assert property (@(posedge clk) disable iff (reset_i)
      $onehot0({fetch_gnt_i, pf_gnt_i}))
      else $error("More than one grant in a cycle");

   // AR held steady until accepted
   ar_stable_a : assert property (@(posedge clk) disable iff (reset_i)
      (ar_valid_i && !ar_ready_i) |=> (ar_valid_i && $stable(ar_addr_i)))
      else $error("AR request dropped or changed before ar_ready_i");

   flush_quiet_a : assert property (@(posedge clk) disable iff (reset_i)
      (flush_i || flush_open_q) |-> !(|fetch_gnt_i || pf_gnt_i))
      else $error("Grant given during a flush");

endmodule

bind shared_icache shared_icache_props shared_icache_props_inst (
   .clk         (clk),
   .reset_i     (reset_i),
   .fetch_gnt_i (fetch_gnt_o),
   .pf_gnt_i    (pf_gnt_o),
   .ar_valid_i  (ar_valid_o),
   .ar_ready_i  (ar_ready_i),
   .ar_addr_i   (ar_addr_o),
   .flush_i     (flush_i),
   .flush_ack_i (flush_ack_o)
);

`default_nettype wire

// ==== bench/shared_icache_tb.sv ====
`default_nettype none

module shared_icache_tb
   import icache_pkg::*;
();

   localparam logic [31:0] SEED = 32'hdc73;
   localparam int N_DIRECTED    = 47;     // Directed fetches and prefetches
   localparam int N_RAND        = 60;
   localparam int N_FLUSH       = 2;
   localparam int REFILL_WORST  = 64;     // Generous cycles per transaction
   localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RAND) * REFILL_WORST
                                 + (N_FLUSH + 1) * NB_SETS * 2 + 100;

   logic                 clk;
   logic                 reset_i;
   core_vec_t            fetch_req_i;
   addr_t [NB_CORES-1:0] fetch_addr_i;
   core_vec_t            fetch_gnt_o, fetch_rvalid_o;
   line_t                fetch_rdata_o;
   logic                 pf_req_i, pf_gnt_o, pf_done_o;
   addr_t                pf_addr_i;
   logic                 flush_i, flush_ack_o;
   logic                 ar_valid_o, ar_ready_i;
   addr_t                ar_addr_o;
   logic                 r_valid_i, r_last_i;
   beat_t                r_data_i;

   tb_clock_gen tb_clock_gen_inst (.clk(clk));

   shared_icache shared_icache_inst (.*);

   ////////////////////
   // Bench state
   ////////////////////
   logic [31:0] lfsr_q;
   line_t       mem_tbl [addr_t];          // Line content per aligned address
   logic        mdl_valid [NB_SETS];       // Reference tag store
   tag_t        mdl_tag [NB_SETS];
   int          rr_ptr;                    // Model round-robin pointer
   logic        slot_full [NB_REQ];        // Next request per requester, pf last
   addr_t       slot_addr [NB_REQ];
   core_vec_t   gnt_seen;
   logic        pf_gnt_seen, s_ar_valid, flush_req, flush_busy;
   addr_t       s_ar_addr;
   logic        pend_valid, pend_hit;      // Transaction in flight
   int          pend_idx, pend_cycle, pend_ars;
   addr_t       pend_addr;
   logic        beats_busy;
   int          beat_k;
   line_t       cur_line;
   int          cycle_cnt, issued, done_cnt, flush_acks;
   int          val_errs, proto_errs;

   ////////////////////
   // Helpers
   ////////////////////
   function automatic logic rand_bit();
      logic lsb;
      lsb    = lfsr_q[0];
      lfsr_q = {1'b0, lfsr_q[31:1]};
      if (lsb) lfsr_q = lfsr_q ^ 32'h8020_0003;   // Galois taps
      return lsb;
   endfunction

   function automatic int unsigned rand_bits(input int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++) v = (v << 1) | rand_bit();
      return v;
   endfunction

   // Clear the byte offset within the line
   function automatic addr_t align_line(input addr_t a);
      return a & ~addr_t'((1 << OFFSET_W) - 1);
   endfunction

   // Small tag and set pool so hits and conflicts both happen
   function automatic addr_t rand_addr();
      addr_t a;
      a = 32'h0004_0000;
      a[ADDR_W-1 -: TAG_W] = a[ADDR_W-1 -: TAG_W] + tag_t'(rand_bits(2));
      a[OFFSET_W +: SET_W] = set_idx_t'(rand_bits(3));
      a[OFFSET_W-1:0]      = OFFSET_W'(rand_bits(OFFSET_W));
      return a;
   endfunction

   function automatic line_t line_for(input addr_t a);
      line_t l;
      if (!mem_tbl.exists(align_line(a))) begin
         for (int i = 0; i < LINE_W; i++) l[i] = rand_bit();
         mem_tbl[align_line(a)] = l;
      end
      return mem_tbl[align_line(a)];
   endfunction

   function automatic core_vec_t rr_pick(input core_vec_t req);
      int c;
      for (int k = 0; k < NB_CORES; k++) begin
         c = (rr_ptr + k) % NB_CORES;
         if (req[c]) return core_vec_t'(1 << c);
      end
      return '0;
   endfunction

   task automatic check_line(input string name, input line_t got, input line_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_vec(input string name, input core_vec_t got, input core_vec_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic complain(input string what);
      proto_errs++;
      $display("At %0t: %s", $time, what);
   endtask

   ////////////////////
   // Drivers and AXI memory
   ////////////////////
   always @(posedge clk) begin
      if (!reset_i) begin
         for (int i = 0; i < NB_CORES; i++) begin
            if (fetch_req_i[i] && gnt_seen[i]) begin
               fetch_req_i[i] <= 1'b0;                 // Granted, drop
            end else if (!fetch_req_i[i] && slot_full[i]) begin
               fetch_req_i[i]  <= 1'b1;
               fetch_addr_i[i] <= slot_addr[i];
               slot_full[i]    = 1'b0;
            end
         end
         if (pf_req_i && pf_gnt_seen) begin
            pf_req_i <= 1'b0;
         end else if (!pf_req_i && slot_full[NB_CORES]) begin
            pf_req_i  <= 1'b1;
            pf_addr_i <= slot_addr[NB_CORES];
            slot_full[NB_CORES] = 1'b0;
         end
         flush_i <= flush_req;
         flush_req = 1'b0;
         // Random gaps on ar_ready_i and between beats
         if (beats_busy) begin
            if (rand_bit()) begin
               r_valid_i <= 1'b1;
               r_data_i  <= cur_line[beat_k*AXI_DATA_W +: AXI_DATA_W];
               r_last_i  <= (beat_k == NB_BEATS - 1);
               if (beat_k == NB_BEATS - 1) beats_busy = 1'b0;
               beat_k++;
            end else begin
               r_valid_i <= 1'b0;
            end
         end else if (s_ar_valid && ar_ready_i) begin
            ar_ready_i <= 1'b0;                        // AR taken at this edge
            r_valid_i  <= 1'b0;
            cur_line   = line_for(s_ar_addr);
            beats_busy = 1'b1;
            beat_k     = 0;
         end else begin
            r_valid_i  <= 1'b0;
            r_last_i   <= 1'b0;
            ar_ready_i <= rand_bit();                  // Ready may lead the request
         end
      end
   end

   ////////////////////
   // Monitor and model
   ////////////////////
   always @(negedge clk) begin
      core_vec_t exp_vec;
      int        idx;
      addr_t     a;
      gnt_seen    = fetch_gnt_o;
      pf_gnt_seen = pf_gnt_o;
      s_ar_valid  = ar_valid_o;
      s_ar_addr   = ar_addr_o;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Run stopped after %0d cycles without finishing", cycle_cnt);
         $display("*** FAILED ***");
         $finish;
      end else if (!reset_i) begin
         cycle_cnt++;
         if (ar_valid_o) begin
            if (!pend_valid || pend_hit) complain("AR issued with no miss pending");
            else check_addr("ar_addr_o", ar_addr_o, align_line(pend_addr));
            if (ar_ready_i) pend_ars++;
         end
         if (|fetch_rvalid_o || pf_done_o) begin
            if (!pend_valid) begin
               complain("Response with no request in flight");
            end else begin
               exp_vec = (pend_idx < NB_CORES) ? core_vec_t'(1 << pend_idx) : '0;
               check_vec("fetch_rvalid_o", fetch_rvalid_o, exp_vec);
               if (pf_done_o != (pend_idx == NB_CORES))
                  complain("pf_done_o does not match the served requester");
               if (pend_idx < NB_CORES)
                  check_line("fetch_rdata_o", fetch_rdata_o, line_for(pend_addr));
               if (pend_hit && cycle_cnt != pend_cycle + 1)
                  complain("Hit response not in the cycle after the grant");
               if (pend_ars != (pend_hit ? 0 : 1))
                  complain("Wrong number of AR requests for this fetch");
               pend_valid = 1'b0;
               done_cnt++;
            end
         end
         if (flush_i) flush_busy = 1'b1;
         if (|fetch_gnt_o || pf_gnt_o) begin
            if (flush_busy) complain("Grant given during a flush");
            if (pend_valid) complain("Grant given while a request is in flight");
            check_vec("fetch_gnt_o", fetch_gnt_o, rr_pick(fetch_req_i));
            if (pf_gnt_o && |fetch_req_i) complain("Prefetch granted over a core request");
            idx = NB_CORES;
            for (int i = 0; i < NB_CORES; i++) if (fetch_gnt_o[i]) idx = i;
            a = (idx < NB_CORES) ? fetch_addr_i[idx] : pf_addr_i;
            pend_valid = 1'b1;
            pend_idx   = idx;
            pend_addr  = a;
            pend_cycle = cycle_cnt;
            pend_ars   = 0;
            pend_hit   = mdl_valid[a[OFFSET_W +: SET_W]] &&
                         mdl_tag[a[OFFSET_W +: SET_W]] == a[ADDR_W-1 -: TAG_W];
            if (!pend_hit) begin                       // Refill replaces the set
               mdl_valid[a[OFFSET_W +: SET_W]] = 1'b1;
               mdl_tag[a[OFFSET_W +: SET_W]]   = a[ADDR_W-1 -: TAG_W];
            end
            if (idx < NB_CORES) rr_ptr = (idx + 1) % NB_CORES;
         end
         if (flush_ack_o) begin
            if (!flush_busy) complain("flush_ack_o without a flush");
            flush_busy = 1'b0;
            flush_acks++;
            for (int s = 0; s < NB_SETS; s++) mdl_valid[s] = 1'b0;
         end
      end
   end

   ////////////////////
   // Sequencer
   ////////////////////
   task automatic fetch(input int c, input addr_t a);
      while (slot_full[c]) @(negedge clk);
      slot_full[c] = 1'b1;
      slot_addr[c] = a;
      issued++;
   endtask

   task automatic drain();
      @(negedge clk);
      while (issued != done_cnt || flush_busy || flush_req || |fetch_req_i || pf_req_i
             || slot_full.or() != 1'b0)
         @(negedge clk);
   endtask

   // Flush strobe with a core request raised in the same cycle
   task automatic flush(input int c, input addr_t a);
      @(negedge clk);
      flush_req = 1'b1;
      fetch(c, a);       // Waits out the sweep
      drain();
   endtask

   initial begin
      addr_t keep;
      lfsr_q       = SEED;
      reset_i      = 1'b1;
      fetch_req_i  = '0;
      fetch_addr_i = '0;
      pf_req_i     = 1'b0;
      pf_addr_i    = '0;
      flush_i      = 1'b0;
      ar_ready_i   = 1'b0;
      r_valid_i    = 1'b0;
      r_data_i     = '0;
      r_last_i     = 1'b0;
      flush_req    = 0;
      flush_busy   = 0;
      pend_valid   = 0;
      beats_busy   = 0;
      rr_ptr       = 0;
      gnt_seen     = '0;
      pf_gnt_seen  = 0;
      s_ar_valid   = 0;
      s_ar_addr    = '0;
      cycle_cnt    = 0;
      issued       = 0;
      done_cnt     = 0;
      flush_acks   = 0;
      val_errs     = 0;
      proto_errs   = 0;
      for (int i = 0; i < NB_REQ; i++) slot_full[i] = 1'b0;
      for (int s = 0; s < NB_SETS; s++) mdl_valid[s] = 1'b0;   // Reset sweep clears all
      repeat (2) @(posedge clk);
      reset_i <= 1'b0;

      // Miss then hit per core
      for (int c = 0; c < NB_CORES; c++) begin
         fetch(c, 32'h0000_1004 + 32'(c * 16));
         drain();
         fetch(c, 32'h0000_1008 + 32'(c * 16));
         drain();
      end
      // All cores at once
      for (int r = 0; r < 6; r++) begin
         @(negedge clk);
         for (int c = 0; c < NB_CORES; c++) fetch(c, rand_addr());
         drain();
      end
      // Prefetch, then cores hit the prefetched lines
      for (int k = 0; k < 3; k++) begin
         fetch(NB_CORES, 32'h0000_8100 + 32'(k * 16));
         drain();
         fetch(k, 32'h0000_810c + 32'(k * 16));
         drain();
      end
      @(negedge clk);
      for (int c = 0; c < NB_REQ; c++) fetch(c, rand_addr());
      drain();
      // Flush drops a cached line
      keep = 32'h0000_2150;
      fetch(1, keep);
      drain();
      fetch(2, keep);
      drain();
      flush(3, keep);
      fetch(0, keep);
      drain();
      // Random traffic with a flush in the middle
      for (int n = 0; n < N_RAND; n++) begin
         idx_sel: begin
            int unsigned c;
            c = rand_bits(3);
            if (c < NB_CORES) fetch(int'(c), rand_addr());
            else              fetch(NB_CORES, rand_addr());
         end
         if (n == N_RAND / 2) begin
            drain();
            flush(n % NB_CORES, rand_addr());
         end
      end
      drain();

      $display("Summary: %0d value errors, %0d protocol errors, %0d transactions, %0d flushes",
               val_errs, proto_errs, done_cnt, flush_acks);
      if (val_errs == 0 && proto_errs == 0 && flush_acks == N_FLUSH) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
   output logic clk
);

   localparam int HALF_PERIOD = 20;   // 40 time unit period

   initial clk = 1'b0;

   always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// ==== files.f ====
logic/icache_pkg.sv
logic/fetch_arbiter.sv
logic/flush_sweep_counter.sv
logic/line_array.sv
logic/refill_assembler.sv
logic/icache_ctrl_fsm.sv
logic/shared_icache.sv
bench/tb_clock_gen.sv
bench/shared_icache_props.sv
bench/shared_icache_tb.sv

// ==== logic/fetch_arbiter.sv ====
`default_nettype none

module fetch_arbiter
   import icache_pkg::*;
(
   input  wire                     clk,
   input  wire                     reset_i,
   input  core_vec_t               core_req_i,
   input  addr_t [NB_CORES-1:0]    core_addr_i,
   input  wire                     pf_req_i,
   input  addr_t                   pf_addr_i,
   input  wire                     accept_i,     // Controller ready for a new request
   output logic                    win_valid_o,
   output req_idx_t                win_idx_o,
   output addr_t                   win_addr_o,
   output core_vec_t               core_gnt_o,
   output logic                    pf_gnt_o
);

   core_idx_t rr_q;       // Highest priority core this cycle
   core_idx_t cand;       // Core under test in the search
   core_idx_t core_win;   // First requesting core from rr_q on
   logic      found;      // Some core is requesting

   ////////////////////
   // Core search
   ////////////////////
   always_comb begin
      found    = 1'b0;
      core_win = rr_q;
      cand     = rr_q;
      // Walk the cores starting at the pointer, keep the first hit
      for (int unsigned k = 0; k < NB_CORES; k++) begin
         cand = core_idx_t'((rr_q + k) % NB_CORES);
         if (!found && core_req_i[cand]) begin
            found    = 1'b1;
            core_win = cand;
         end
      end
   end

   // Prefetcher only wins when no core asks
   assign win_valid_o = found | pf_req_i;
   assign win_idx_o   = found ? req_idx_t'(core_win) : PF_IDX;
   assign win_addr_o  = found ? core_addr_i[core_win] : pf_addr_i;

   // One-hot grant gated by the controller
   always_comb begin
      for (int unsigned i = 0; i < NB_CORES; i++) begin
         core_gnt_o[i] = accept_i & found & (core_win == core_idx_t'(i));
      end
   end

   assign pf_gnt_o = accept_i & ~found & pf_req_i;

   // Pointer moves past the granted core, prefetch grants leave it alone
   always_ff @(posedge clk) begin
      if (reset_i) begin
         rr_q <= '0;
      end else if (accept_i && found) begin
         rr_q <= core_idx_t'((core_win + 1) % NB_CORES);
      end
   end

endmodule

`default_nettype wire

// ==== logic/flush_sweep_counter.sv ====
`default_nettype none

module flush_sweep_counter
   import icache_pkg::*;
(
   input  wire        clk,
   input  wire        reset_i,
   input  wire        sweep_start_i,
   output logic       sweeping_o,
   output set_idx_t   sweep_set_o,
   output logic       sweep_last_o
);

   logic     sweeping_q;
   set_idx_t set_q;

   assign sweeping_o   = sweeping_q;
   assign sweep_set_o  = set_q;
   assign sweep_last_o = sweeping_q & (set_q == set_idx_t'(NB_SETS - 1));  // Final set

   // One set per cycle, stop after the last one
   always_ff @(posedge clk) begin
      if (reset_i || sweep_start_i) begin
         sweeping_q <= 1'b1;         // Reset invalidates the whole array too
         set_q      <= '0;
      end else if (sweeping_q) begin
         if (sweep_last_o) sweeping_q <= 1'b0;
         else              set_q      <= set_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/icache_ctrl_fsm.sv ====
`default_nettype none

module icache_ctrl_fsm
   import icache_pkg::*;
(
   input  wire           clk,
   input  wire           reset_i,
   // Winner from the arbiter
   input  wire           win_valid_i,
   input  req_idx_t      win_idx_i,
   input  addr_t         win_addr_i,
   // Array read side
   input  tag_entry_t    tag_rdata_i,
   input  line_t         line_rdata_i,
   // Flush sweep
   input  wire           sweeping_i,
   input  set_idx_t      sweep_set_i,
   input  wire           sweep_last_i,
   // Refill line
   input  wire           line_valid_i,
   input  line_t         line_i,
   input  wire           ar_ready_i,
   input  wire           flush_i,
   output logic          accept_o,
   output set_idx_t      array_idx_o,
   output logic          tag_we_o,
   output tag_entry_t    tag_wdata_o,
   output logic          line_we_o,
   output logic          sweep_start_o,
   output logic          ar_valid_o,
   output addr_t         ar_addr_o,
   output core_vec_t     fetch_rvalid_o,
   output line_t         fetch_rdata_o,
   output logic          pf_done_o,
   output logic          flush_ack_o
);

   ctrl_state_t state_q, state_d;
   req_idx_t    req_idx_q;              // Requester being served
   addr_t       req_addr_q;             // Its fetch address
   logic        flush_pend_q;           // Strobe seen, sweep not started yet
   logic        ack_owed_q;             // Running sweep came from a strobe
   logic        flush_ack_q;
   set_idx_t    req_set;
   tag_t        req_tag;
   logic        hit;
   logic        respond;                // Response to the current requester

   assign req_set = req_addr_q[OFFSET_W +: SET_W];
   assign req_tag = req_addr_q[ADDR_W-1 -: TAG_W];
   assign hit     = tag_rdata_i.valid & (tag_rdata_i.tag == req_tag);

   ////////////////////
   // Handshakes
   ////////////////////
   // No grant while a flush is requested, pending or just acked
   assign accept_o      = (state_q == IDLE) & ~flush_pend_q & ~flush_i & ~flush_ack_q;
   assign sweep_start_o = (state_q == IDLE) & flush_pend_q;
   assign ar_valid_o    = ((state_q == LOOKUP) & ~hit) | (state_q == AR_REQ);
   assign ar_addr_o     = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // Line aligned
   assign respond       = ((state_q == LOOKUP) & hit) | ((state_q == WAIT_R) & line_valid_i);
   assign fetch_rdata_o = (state_q == WAIT_R) ? line_i : line_rdata_i;  // Refill or hit data
   assign pf_done_o     = respond & (req_idx_q == PF_IDX);
   assign flush_ack_o   = flush_ack_q;

   always_comb begin
      for (int unsigned i = 0; i < NB_CORES; i++) begin
         fetch_rvalid_o[i] = respond & (req_idx_q == req_idx_t'(i));
      end
   end

   ////////////////////
   // Array port
   ////////////////////
   always_comb begin
      case (state_q)
         IDLE:    array_idx_o = win_addr_i[OFFSET_W +: SET_W];  // Read at the grant edge
         FLUSH:   array_idx_o = sweep_set_i;
         default: array_idx_o = req_set;
      endcase
   end

   // Sweep clears entries, refill writes tag and line with the response
   assign tag_we_o          = ((state_q == FLUSH) & sweeping_i) | ((state_q == WAIT_R) & line_valid_i);
   assign line_we_o         = (state_q == WAIT_R) & line_valid_i;
   assign tag_wdata_o.valid = (state_q != FLUSH);
   assign tag_wdata_o.tag   = (state_q == FLUSH) ? '0 : req_tag;

   ////////////////////
   // Next state
   ////////////////////
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (flush_pend_q)                 state_d = FLUSH;
            else if (win_valid_i && accept_o) state_d = LOOKUP;
         end
         LOOKUP: begin
            if (!hit) state_d = ar_ready_i ? WAIT_R : AR_REQ;  // AR may go out at once
            else      state_d = IDLE;
         end
         AR_REQ:  if (ar_ready_i) state_d = WAIT_R;
         WAIT_R:  if (line_valid_i) state_d = IDLE;    // Last beat closes the refill
         FLUSH:   if (sweep_last_i) state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q      <= FLUSH;   // Counter sweeps out of reset
         flush_pend_q <= 1'b0;
         ack_owed_q   <= 1'b0;
         flush_ack_q  <= 1'b0;
      end else begin
         state_q     <= state_d;
         flush_ack_q <= (state_q == FLUSH) & sweep_last_i & ack_owed_q;
         if (sweep_start_o)                        flush_pend_q <= 1'b0;
         else if (flush_i && (state_q != FLUSH))   flush_pend_q <= 1'b1;  // Absorb repeats
         if (sweep_start_o)                        ack_owed_q <= 1'b1;
         else if (flush_ack_q)                     ack_owed_q <= 1'b0;
      end
   end

   // Request capture at the grant
   always_ff @(posedge clk) begin
      if (win_valid_i && accept_o) begin
         req_idx_q  <= win_idx_i;
         req_addr_q <= win_addr_i;
      end
   end

endmodule

`default_nettype wire

// ==== logic/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

   ////////////////////
   // Geometry
   ////////////////////
   localparam int unsigned NB_CORES   = 4;
   localparam int unsigned NB_REQ     = NB_CORES + 1;           // Cores plus prefetcher
   localparam int unsigned ADDR_W     = 32;
   localparam int unsigned LINE_W     = 128;
   localparam int unsigned AXI_DATA_W = 64;
   localparam int unsigned NB_BEATS   = LINE_W / AXI_DATA_W;    // Read beats per refill
   localparam int unsigned OFFSET_W   = 4;                      // Byte offset in a line
   localparam int unsigned SET_W      = 5;
   localparam int unsigned NB_SETS    = 32;
   localparam int unsigned TAG_W      = ADDR_W - SET_W - OFFSET_W;

   // Derived index widths
   localparam int unsigned REQ_IDX_W  = $clog2(NB_REQ);
   localparam int unsigned CORE_IDX_W = $clog2(NB_CORES);
   localparam int unsigned BEAT_IDX_W = $clog2(NB_BEATS);

   ////////////////////
   // Types
   ////////////////////
   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [LINE_W-1:0]     line_t;
   typedef logic [AXI_DATA_W-1:0] beat_t;
   typedef logic [SET_W-1:0]      set_idx_t;
   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [NB_CORES-1:0]   core_vec_t;
   typedef logic [REQ_IDX_W-1:0]  req_idx_t;   // Top value selects the prefetcher
   typedef logic [CORE_IDX_W-1:0] core_idx_t;
   typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

   // One tag array entry
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   localparam req_idx_t PF_IDX = req_idx_t'(NB_REQ - 1);   // Prefetcher requester id

   // Controller states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      AR_REQ,
      WAIT_R,
      FLUSH
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/line_array.sv ====
`default_nettype none

module line_array
   import icache_pkg::*;
#(
   parameter type payload_t = line_t
) (
   input  wire        clk,
   input  set_idx_t   idx_i,
   input  wire        we_i,
   input  payload_t   wdata_i,
   output payload_t   rdata_o
);

   payload_t mem_q [NB_SETS];   // One entry per set

   ////////////////////
   // Storage
   ////////////////////
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem_q[idx_i] <= wdata_i;
      end
   end

   // Registered read, old data on a same-cycle write
   always_ff @(posedge clk) begin
      rdata_o <= mem_q[idx_i];
   end

endmodule

`default_nettype wire

// ==== logic/refill_assembler.sv ====
`default_nettype none

module refill_assembler
   import icache_pkg::*;
(
   input  wire      clk,
   input  wire      reset_i,
   input  wire      r_valid_i,
   input  beat_t    r_data_i,
   input  wire      r_last_i,
   output logic     line_valid_o,
   output line_t    line_o
);

   beat_idx_t               beat_q;    // Slot of the next early beat
   beat_t [NB_BEATS-2:0]    hold_q;    // Early beats, lowest first

   ////////////////////
   // Beat capture
   ////////////////////
   always_ff @(posedge clk) begin
      if (reset_i) begin
         beat_q <= '0;
      end else if (r_valid_i) begin
         if (r_last_i) beat_q <= '0;              // Ready for the next refill
         else          beat_q <= beat_q + 1'b1;
      end
   end

   // Early beats in arrival order
   always_ff @(posedge clk) begin
      if (r_valid_i && !r_last_i) begin
         hold_q[beat_q] <= r_data_i;
      end
   end

   // Last beat goes on top of the stored ones
   assign line_o       = {r_data_i, hold_q};
   assign line_valid_o = r_valid_i & r_last_i;

endmodule

`default_nettype wire

// ==== logic/shared_icache.sv ====
`default_nettype none

module shared_icache
   import icache_pkg::*;
(
   input  wire                    clk,
   input  wire                    reset_i,
   // Core fetch ports
   input  core_vec_t              fetch_req_i,
   input  addr_t [NB_CORES-1:0]   fetch_addr_i,
   output core_vec_t              fetch_gnt_o,
   output core_vec_t              fetch_rvalid_o,
   output line_t                  fetch_rdata_o,
   // Prefetcher
   input  wire                    pf_req_i,
   input  addr_t                  pf_addr_i,
   output logic                   pf_gnt_o,
   output logic                   pf_done_o,
   // Flush
   input  wire                    flush_i,
   output logic                   flush_ack_o,
   // AXI read
   output logic                   ar_valid_o,
   output addr_t                  ar_addr_o,
   input  wire                    ar_ready_i,
   input  wire                    r_valid_i,
   input  beat_t                  r_data_i,
   input  wire                    r_last_i
);

   logic       win_valid;
   req_idx_t   win_idx;
   addr_t      win_addr;
   logic       accept;
   set_idx_t   array_idx;      // Shared index of both arrays
   logic       tag_we;
   tag_entry_t tag_wdata;
   tag_entry_t tag_rdata;
   logic       line_we;
   line_t      line_rdata;
   logic       sweep_start;
   logic       sweeping;
   set_idx_t   sweep_set;
   logic       sweep_last;
   logic       line_valid;
   line_t      line;           // Assembled refill line

   ////////////////////
   // Request side
   ////////////////////
   fetch_arbiter fetch_arbiter_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .core_req_i  (fetch_req_i),
      .core_addr_i (fetch_addr_i),
      .pf_req_i    (pf_req_i),
      .pf_addr_i   (pf_addr_i),
      .accept_i    (accept),
      .win_valid_o (win_valid),
      .win_idx_o   (win_idx),
      .win_addr_o  (win_addr),
      .core_gnt_o  (fetch_gnt_o),
      .pf_gnt_o    (pf_gnt_o)
   );

   icache_ctrl_fsm icache_ctrl_fsm_inst (
      .clk            (clk),
      .reset_i        (reset_i),
      .win_valid_i    (win_valid),
      .win_idx_i      (win_idx),
      .win_addr_i     (win_addr),
      .tag_rdata_i    (tag_rdata),
      .line_rdata_i   (line_rdata),
      .sweeping_i     (sweeping),
      .sweep_set_i    (sweep_set),
      .sweep_last_i   (sweep_last),
      .line_valid_i   (line_valid),
      .line_i         (line),
      .ar_ready_i     (ar_ready_i),
      .flush_i        (flush_i),
      .accept_o       (accept),
      .array_idx_o    (array_idx),
      .tag_we_o       (tag_we),
      .tag_wdata_o    (tag_wdata),
      .line_we_o      (line_we),
      .sweep_start_o  (sweep_start),
      .ar_valid_o     (ar_valid_o),
      .ar_addr_o      (ar_addr_o),
      .fetch_rvalid_o (fetch_rvalid_o),
      .fetch_rdata_o  (fetch_rdata_o),
      .pf_done_o      (pf_done_o),
      .flush_ack_o    (flush_ack_o)
   );

   flush_sweep_counter flush_sweep_counter_inst (
      .clk           (clk),
      .reset_i       (reset_i),
      .sweep_start_i (sweep_start),
      .sweeping_o    (sweeping),
      .sweep_set_o   (sweep_set),
      .sweep_last_o  (sweep_last)
   );

   ////////////////////
   // Storage and refill
   ////////////////////
   line_array #(.payload_t(tag_entry_t)) tag_array_inst (
      .clk     (clk),
      .idx_i   (array_idx),
      .we_i    (tag_we),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata)
   );

   line_array #(.payload_t(line_t)) data_array_inst (
      .clk     (clk),
      .idx_i   (array_idx),
      .we_i    (line_we),
      .wdata_i (line),            // Only written by a refill
      .rdata_o (line_rdata)
   );

   refill_assembler refill_assembler_inst (
      .clk          (clk),
      .reset_i      (reset_i),
      .r_valid_i    (r_valid_i),
      .r_data_i     (r_data_i),
      .r_last_i     (r_last_i),
      .line_valid_o (line_valid),
      .line_o       (line)
   );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the shared_icache simulation with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log
BIN=sim_shared_icache

verilator --binary --timing --assert -Wno-fatal \
   --top-module shared_icache_tb -f files.f -o "$BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
